// File: common/cache_pkg.sv
// Shared widths, bus cycle codes and engine states for the cache tag unit
// Modules pull these in with a wildcard import in their header

package cache_pkg;

        // Bus field types
        typedef logic [31:0] addr_t;
        typedef logic [31:0] word_t;
        typedef logic [3:0]  sel_t;
        typedef logic [2:0]  cti_t;

        // Cycle type codes
        localparam cti_t CTI_CLASSIC = 3'b000;
        localparam cti_t CTI_BURST   = 3'b010;
        localparam cti_t CTI_EOB     = 3'b111;

        // Lines examined per dirty scan step
        localparam int GROUP_LINES = 16;

        typedef enum logic [2:0] {
                ST_IDLE,
                ST_SCAN,
                ST_READ_WAIT,
                ST_WRITE,
                ST_INV
        } clean_state_t;

        // Physical line number below the virtual tag
        function automatic int tag_width(input int size, input int line);
                return (32 - $clog2(line)) + (32 - $clog2(size / line) - $clog2(line));
        endfunction

endpackage

// File: common/store_if.sv
`timescale 1ns/100ps
// Link between the maintenance engine and the line store
// The engine requests maintenance reads and strobes, the store returns data

interface store_if
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 1024,
        parameter int CACHE_LINE = 8
)
();
        localparam int LINES = CACHE_SIZE / CACHE_LINE;
        localparam int IDX_W = $clog2(LINES);
        localparam int TAG_W = tag_width(CACHE_SIZE, CACHE_LINE);

        // Engine side
        logic                    busy;
        logic [IDX_W-1:0]        maint_index;
        logic                    clean_line;
        logic                    clear_all;

        // Store side
        logic [LINES-1:0]        dirty_vec;
        logic [TAG_W-1:0]        rd_tag;
        logic [CACHE_LINE*8-1:0] rd_line;

        modport store (
                input  busy, maint_index, clean_line, clear_all,
                output dirty_vec, rd_tag, rd_line
        );

        modport engine (
                output busy, maint_index, clean_line, clear_all,
                input  dirty_vec, rd_tag, rd_line
        );

endinterface

// File: design/cache_ram.sv
`timescale 1ns/100ps
// Simple dual port RAM with one write port and one registered read port
// A same-address write is forwarded to the read output

module cache_ram #(
        parameter int WIDTH = 8,
        parameter int DEPTH = 128
)
(
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  logic [WIDTH-1:0]         i_wr_data,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        output logic [WIDTH-1:0]         o_rd_data
);

logic [WIDTH-1:0] mem [DEPTH];

always_ff @(posedge i_clk)
begin
        if (i_wr_en)
                mem[i_wr_addr] <= i_wr_data;

        // Write first on a collision
        if (i_wr_en && i_wr_addr == i_rd_addr)
                o_rd_data <= i_wr_data;
        else
                o_rd_data <= mem[i_rd_addr];
end

endmodule

// File: line_store/line_store.sv
`timescale 1ns/100ps
// Tag and data store of the cache with valid and dirty tracking
// Lookups own the read port when idle, the maintenance engine when busy

module line_store
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 1024,
        parameter int CACHE_LINE = 8
)
(
        input  logic                                          i_clk,
        input  logic                                          i_reset,
        input  addr_t                                         i_address_nxt,
        input  addr_t                                         i_address,
        input  logic                                          i_cache_tag_wr_en,
        input  logic [tag_width(CACHE_SIZE, CACHE_LINE)-1:0]  i_cache_tag,
        input  logic [CACHE_LINE*8-1:0]                       i_cache_line,
        input  logic [CACHE_LINE-1:0]                         i_cache_line_ben,
        input  logic                                          i_cache_tag_dirty,
        output logic [tag_width(CACHE_SIZE, CACHE_LINE)-1:0]  o_cache_tag,
        output logic [CACHE_LINE*8-1:0]                       o_cache_line,
        output logic                                          o_cache_tag_valid,
        output logic                                          o_cache_tag_dirty,
        store_if.store                                        sif
);

localparam int LINES = CACHE_SIZE / CACHE_LINE;
localparam int IDX_W = $clog2(LINES);
localparam int OFF_W = $clog2(CACHE_LINE);
localparam int TAG_W = tag_width(CACHE_SIZE, CACHE_LINE);

logic [IDX_W-1:0] rd_idx;
logic [IDX_W-1:0] wr_idx;
logic             wr_en;
logic             bypass;
logic [LINES-1:0] valid_q;
logic [LINES-1:0] dirty_q;

// --------------------------------------------------
// Address selection
// --------------------------------------------------

assign wr_idx = i_address[OFF_W +: IDX_W];
assign rd_idx = sif.busy ? sif.maint_index : i_address_nxt[OFF_W +: IDX_W];

// No lookup writes while maintenance runs
assign wr_en  = i_cache_tag_wr_en && !sif.busy;
assign bypass = wr_en && (wr_idx == rd_idx);

// --------------------------------------------------
// Tag and data arrays
// --------------------------------------------------

cache_ram #(.WIDTH(TAG_W), .DEPTH(LINES)) u_tag_ram (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_idx),
        .i_wr_data (i_cache_tag),
        .i_rd_addr (rd_idx),
        .o_rd_data (o_cache_tag)
);

// One RAM per byte lane so the byte enables need no merge
for (genvar i = 0; i < CACHE_LINE; i++)
begin : g_lane
        cache_ram #(.WIDTH(8), .DEPTH(LINES)) u_data_ram (
                .i_clk     (i_clk),
                .i_wr_en   (wr_en && i_cache_line_ben[i]),
                .i_wr_addr (wr_idx),
                .i_wr_data (i_cache_line[i*8 +: 8]),
                .i_rd_addr (rd_idx),
                .o_rd_data (o_cache_line[i*8 +: 8])
        );
end

assign sif.rd_tag    = o_cache_tag;
assign sif.rd_line   = o_cache_line;
assign sif.dirty_vec = dirty_q;

// --------------------------------------------------
// Valid and dirty state
// --------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid_q           <= '0;
                dirty_q           <= '0;
                o_cache_tag_valid <= 1'b0;
                o_cache_tag_dirty <= 1'b0;
        end
        else
        begin
                o_cache_tag_valid <= bypass ? 1'b1 : valid_q[rd_idx];
                o_cache_tag_dirty <= bypass ? i_cache_tag_dirty : dirty_q[rd_idx];

                if (sif.clear_all)
                        valid_q <= '0;
                else if (wr_en)
                        valid_q[wr_idx] <= 1'b1;

                // Strobes only come while busy, so they never meet a write
                if (wr_en)
                        dirty_q[wr_idx] <= i_cache_tag_dirty;
                else if (sif.clean_line)
                        dirty_q[sif.maint_index] <= 1'b0;
        end
end

endmodule

// File: maint_engine/dirty_scan.sv
`timescale 1ns/100ps
// Finds the lowest dirty line inside one group of lines
// Purely combinational logic while the engine steps the group number

module dirty_scan
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 1024,
        parameter int CACHE_LINE = 8
)
(
        input  logic [CACHE_SIZE/CACHE_LINE-1:0]                         i_dirty_vec,
        input  logic [$clog2(CACHE_SIZE/CACHE_LINE/GROUP_LINES)-1:0]     i_group,
        output logic                                                     o_found,
        output logic [$clog2(CACHE_SIZE/CACHE_LINE)-1:0]                 o_index
);

// Line position inside a group
localparam int ENC_W = $clog2(GROUP_LINES);

logic [GROUP_LINES-1:0] grp_bits;
logic [ENC_W-1:0]       enc;

always_comb
begin
        grp_bits = i_dirty_vec[i_group * GROUP_LINES +: GROUP_LINES];
        o_found  = |grp_bits;
        enc      = '0;

        // Walk downward so the lowest set bit wins
        for (int j = GROUP_LINES - 1; j >= 0; j--)
        begin
                if (grp_bits[j])
                        enc = ENC_W'(j);
        end

        o_index = {i_group, enc};
end

endmodule

// File: maint_engine/maint_engine.sv
`timescale 1ns/100ps
// Global clean and invalidate engine for the cache store
// Dirty lines go out as incrementing write bursts to their physical address

module maint_engine
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 1024,
        parameter int CACHE_LINE = 8
)
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_cache_clean_req,
        input  logic    i_cache_inv_req,
        output logic    o_cache_clean_done,
        output logic    o_cache_inv_done,
        store_if.engine sif,
        output logic    o_wb_cyc,
        output logic    o_wb_stb,
        output logic    o_wb_we,
        output addr_t   o_wb_adr,
        output word_t   o_wb_dat,
        output sel_t    o_wb_sel,
        output cti_t    o_wb_cti,
        input  logic    i_wb_ack
);

localparam int LINES  = CACHE_SIZE / CACHE_LINE;
localparam int IDX_W  = $clog2(LINES);
localparam int OFF_W  = $clog2(CACHE_LINE);
localparam int PA_W   = 32 - OFF_W;
localparam int WORDS  = CACHE_LINE / 4;
localparam int WORD_W = (WORDS > 1) ? $clog2(WORDS) : 1;
localparam int GROUPS = LINES / GROUP_LINES;
localparam int GRP_W  = $clog2(GROUPS);

clean_state_t      state_q;
logic [GRP_W-1:0]  group_q;
logic [IDX_W-1:0]  line_idx_q;
logic [IDX_W-1:0]  scan_idx;
logic              scan_found;
logic [WORD_W-1:0] word_q;
logic [WORD_W-1:0] word_nxt;
logic              clean_done_q;
logic              ack_seen;
logic              last_word;
logic              load_word;
cti_t              cti_nxt;
addr_t             pa_base;

dirty_scan #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_dirty_scan (
        .i_dirty_vec (sif.dirty_vec),
        .i_group     (group_q),
        .o_found     (scan_found),
        .o_index     (scan_idx)
);

// --------------------------------------------------
// Burst word selection
// --------------------------------------------------

always_comb
begin
        ack_seen  = o_wb_stb && i_wb_ack;
        last_word = (word_q == WORD_W'(WORDS - 1));
        word_nxt  = (state_q == ST_READ_WAIT) ? '0 : word_q + 1'b1;
        cti_nxt   = (word_nxt == WORD_W'(WORDS - 1)) ? CTI_EOB : CTI_BURST;
        pa_base   = {sif.rd_tag[PA_W-1:0], {OFF_W{1'b0}}};

        // First word after the read wait, later ones on each ack
        load_word = (state_q == ST_READ_WAIT) ||
                    (state_q == ST_WRITE && ack_seen && !last_word);
end

// Store reads the scan result early so data is ready in ST_READ_WAIT
assign sif.maint_index = (state_q == ST_SCAN) ? scan_idx : line_idx_q;
assign sif.busy        = (state_q != ST_IDLE);
assign sif.clean_line  = (state_q == ST_WRITE) && ack_seen && last_word;
assign sif.clear_all   = (state_q == ST_INV);

assign o_cache_inv_done   = (state_q == ST_INV);
assign o_cache_clean_done = clean_done_q;

// --------------------------------------------------
// FSM and bus control
// --------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q      <= ST_IDLE;
                group_q      <= '0;
                line_idx_q   <= '0;
                word_q       <= '0;
                clean_done_q <= 1'b0;
                o_wb_cyc     <= 1'b0;
                o_wb_stb     <= 1'b0;
                o_wb_we      <= 1'b0;
                o_wb_sel     <= '0;
                o_wb_cti     <= CTI_CLASSIC;
        end
        else
        begin
                clean_done_q <= 1'b0;

                if (load_word)
                begin
                        word_q   <= word_nxt;
                        o_wb_cti <= cti_nxt;
                end

                case (state_q)
                ST_IDLE:
                begin
                        // Requests held over into the done cycle are dropped
                        if (i_cache_clean_req && !clean_done_q)
                        begin
                                group_q <= '0;
                                state_q <= ST_SCAN;
                        end
                        else if (i_cache_inv_req && !clean_done_q)
                                state_q <= ST_INV;
                end
                ST_SCAN:
                begin
                        if (scan_found)
                        begin
                                line_idx_q <= scan_idx;
                                state_q    <= ST_READ_WAIT;
                        end
                        else if (group_q == GRP_W'(GROUPS - 1))
                        begin
                                clean_done_q <= 1'b1;
                                state_q      <= ST_IDLE;
                        end
                        else
                                group_q <= group_q + 1'b1;
                end
                ST_READ_WAIT:
                begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= 1'b1;
                        o_wb_sel <= '1;
                        state_q  <= ST_WRITE;
                end
                ST_WRITE:
                begin
                        if (ack_seen && last_word)
                        begin
                                o_wb_cyc <= 1'b0;
                                o_wb_stb <= 1'b0;
                                o_wb_we  <= 1'b0;
                                o_wb_sel <= '0;
                                o_wb_cti <= CTI_CLASSIC;
                                state_q  <= ST_SCAN;
                        end
                end
                default:
                        state_q <= ST_IDLE;
                endcase
        end
end

// Address and data of the word being presented
always_ff @(posedge i_clk)
begin
        if (load_word)
        begin
                o_wb_adr <= pa_base + addr_t'({word_nxt, 2'b00});
                o_wb_dat <= sif.rd_line[32*word_nxt +: 32];
        end
end

endmodule

// File: design/cache_tag_unit.sv
`timescale 1ns/100ps
// Top of the cache tag unit, joining the line store and maintenance engine
// Lookup, maintenance request and write-back bus ports are plain ports

module cache_tag_unit
        import cache_pkg::*;
#(
        parameter int CACHE_SIZE = 1024,
        parameter int CACHE_LINE = 8
)
(
        input  logic                                          i_clk,
        input  logic                                          i_reset,
        // Lookup
        input  addr_t                                         i_address_nxt,
        input  addr_t                                         i_address,
        input  logic                                          i_cache_tag_wr_en,
        input  logic [tag_width(CACHE_SIZE, CACHE_LINE)-1:0]  i_cache_tag,
        input  logic [CACHE_LINE*8-1:0]                       i_cache_line,
        input  logic [CACHE_LINE-1:0]                         i_cache_line_ben,
        input  logic                                          i_cache_tag_dirty,
        output logic [tag_width(CACHE_SIZE, CACHE_LINE)-1:0]  o_cache_tag,
        output logic [CACHE_LINE*8-1:0]                       o_cache_line,
        output logic                                          o_cache_tag_valid,
        output logic                                          o_cache_tag_dirty,
        // Maintenance
        input  logic                                          i_cache_clean_req,
        output logic                                          o_cache_clean_done,
        input  logic                                          i_cache_inv_req,
        output logic                                          o_cache_inv_done,
        // Write-back bus
        output logic                                          o_wb_cyc,
        output logic                                          o_wb_stb,
        output logic                                          o_wb_we,
        output addr_t                                         o_wb_adr,
        output word_t                                         o_wb_dat,
        output sel_t                                          o_wb_sel,
        output cti_t                                          o_wb_cti,
        input  logic                                          i_wb_ack
);

store_if #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_store_if ();

line_store #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_line_store (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_address_nxt     (i_address_nxt),
        .i_address         (i_address),
        .i_cache_tag_wr_en (i_cache_tag_wr_en),
        .i_cache_tag       (i_cache_tag),
        .i_cache_line      (i_cache_line),
        .i_cache_line_ben  (i_cache_line_ben),
        .i_cache_tag_dirty (i_cache_tag_dirty),
        .o_cache_tag       (o_cache_tag),
        .o_cache_line      (o_cache_line),
        .o_cache_tag_valid (o_cache_tag_valid),
        .o_cache_tag_dirty (o_cache_tag_dirty),
        .sif               (u_store_if.store)
);

maint_engine #(.CACHE_SIZE(CACHE_SIZE), .CACHE_LINE(CACHE_LINE)) u_maint_engine (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_cache_clean_req  (i_cache_clean_req),
        .i_cache_inv_req    (i_cache_inv_req),
        .o_cache_clean_done (o_cache_clean_done),
        .o_cache_inv_done   (o_cache_inv_done),
        .sif                (u_store_if.engine),
        .o_wb_cyc           (o_wb_cyc),
        .o_wb_stb           (o_wb_stb),
        .o_wb_we            (o_wb_we),
        .o_wb_adr           (o_wb_adr),
        .o_wb_dat           (o_wb_dat),
        .o_wb_sel           (o_wb_sel),
        .o_wb_cti           (o_wb_cti),
        .i_wb_ack           (i_wb_ack)
);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/100ps
// Clock and reset source for the testbench
// Reset is held high for a fixed number of rising edges

module tb_clock #(
        parameter int PERIOD       = 10,
        parameter int RESET_CYCLES = 5
)
(
        output logic o_clk,
        output logic o_reset
);

initial
begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
end

initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/100ps
// Testbench for the cache tag unit covering lookups, bypass, global clean and invalidate
// A reference model of tags, lines, valid and dirty bits gives the expected values

module tb_top;

localparam int CACHE_SIZE    = 1024;
localparam int CACHE_LINE    = 8;
localparam int LINES         = CACHE_SIZE / CACHE_LINE;
localparam int IDX_W         = $clog2(LINES);
localparam int OFF_W         = $clog2(CACHE_LINE);
localparam int WORDS         = CACHE_LINE / 4;
localparam int LINE_W        = CACHE_LINE * 8;
localparam int PA_W          = 32 - OFF_W;
localparam int TAG_W         = PA_W + (32 - IDX_W - OFF_W);
localparam int CLEAN_TIMEOUT = 20000;

logic                    i_clk;
logic                    i_reset;
logic [31:0]             i_address_nxt     = '0;
logic [31:0]             i_address         = '0;
logic                    i_cache_tag_wr_en = 1'b0;
logic [TAG_W-1:0]        i_cache_tag       = '0;
logic [LINE_W-1:0]       i_cache_line      = '0;
logic [CACHE_LINE-1:0]   i_cache_line_ben  = '0;
logic                    i_cache_tag_dirty = 1'b0;
logic                    i_cache_clean_req = 1'b0;
logic                    i_cache_inv_req   = 1'b0;
logic                    i_wb_ack          = 1'b0;
logic [TAG_W-1:0]        o_cache_tag;
logic [LINE_W-1:0]       o_cache_line;
logic                    o_cache_tag_valid;
logic                    o_cache_tag_dirty;
logic                    o_cache_clean_done;
logic                    o_cache_inv_done;
logic                    o_wb_cyc;
logic                    o_wb_stb;
logic                    o_wb_we;
logic [31:0]             o_wb_adr;
logic [31:0]             o_wb_dat;
logic [3:0]              o_wb_sel;
logic [2:0]              o_wb_cti;

// Reference model
logic [TAG_W-1:0]  ref_tag   [LINES];
logic [LINE_W-1:0] ref_line  [LINES];
logic              ref_valid [LINES];
logic              ref_dirty [LINES];
logic [66:0]       exp_bus   [$];
logic [66:0]       bus_exp;

// Read expectation of the presented cycle and of the checked cycle
logic              rd_req       = 1'b0;
string             rd_name      = "";
logic              rd_known     = 1'b0;
logic [TAG_W-1:0]  rd_exp_tag   = '0;
logic [LINE_W-1:0] rd_exp_line  = '0;
logic              rd_exp_valid = 1'b0;
logic              rd_exp_dirty = 1'b0;
logic              cmp_pending  = 1'b0;
string             cmp_name     = "";
logic              cmp_known    = 1'b0;
logic [TAG_W-1:0]  cmp_tag      = '0;
logic [LINE_W-1:0] cmp_line     = '0;
logic              cmp_valid    = 1'b0;
logic              cmp_dirty    = 1'b0;
logic [1:0]        ack_delay    = 2'd0;

tb_clock u_clock (
        .o_clk   (i_clk),
        .o_reset (i_reset)
);

cache_tag_unit dut (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_address_nxt      (i_address_nxt),
        .i_address          (i_address),
        .i_cache_tag_wr_en  (i_cache_tag_wr_en),
        .i_cache_tag        (i_cache_tag),
        .i_cache_line       (i_cache_line),
        .i_cache_line_ben   (i_cache_line_ben),
        .i_cache_tag_dirty  (i_cache_tag_dirty),
        .o_cache_tag        (o_cache_tag),
        .o_cache_line       (o_cache_line),
        .o_cache_tag_valid  (o_cache_tag_valid),
        .o_cache_tag_dirty  (o_cache_tag_dirty),
        .i_cache_clean_req  (i_cache_clean_req),
        .o_cache_clean_done (o_cache_clean_done),
        .i_cache_inv_req    (i_cache_inv_req),
        .o_cache_inv_done   (o_cache_inv_done),
        .o_wb_cyc           (o_wb_cyc),
        .o_wb_stb           (o_wb_stb),
        .o_wb_we            (o_wb_we),
        .o_wb_adr           (o_wb_adr),
        .o_wb_dat           (o_wb_dat),
        .o_wb_sel           (o_wb_sel),
        .o_wb_cti           (o_wb_cti),
        .i_wb_ack           (i_wb_ack)
);

// --------------------------------------------------
// Reference functions and helpers
// --------------------------------------------------

task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
endtask

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else
        begin
                $display("mismatch in %s: expected %0h, actual %0h", name, exp, act);
                abort_run();
        end
endtask

// Enabled bytes take the new data and the rest keep the stored line
function automatic logic [LINE_W-1:0] merge_bytes(input logic [LINE_W-1:0] old_line,
                                                  input logic [LINE_W-1:0] new_line,
                                                  input logic [CACHE_LINE-1:0] ben);
        logic [LINE_W-1:0] merged;
        merged = old_line;
        for (int b = 0; b < CACHE_LINE; b++)
                if (ben[b])
                        merged[8*b +: 8] = new_line[8*b +: 8];
        return merged;
endfunction

// Expected write-back word k of a line as {address, data, cycle type}
function automatic logic [66:0] bus_word(input int idx, input int k);
        logic [31:0] adr;
        logic [31:0] dat;
        logic [2:0]  cti;
        adr = {ref_tag[idx][PA_W-1:0], {OFF_W{1'b0}}} + 32'(4 * k);
        dat = ref_line[idx][32*k +: 32];
        // Incrementing burst with the end of burst code on the last word
        cti = (k == WORDS - 1) ? 3'b111 : 3'b010;
        return {adr, dat, cti};
endfunction

function automatic void model_write(input int idx, input logic [TAG_W-1:0] tag,
                                    input logic [LINE_W-1:0] line,
                                    input logic [CACHE_LINE-1:0] ben, input logic dirty);
        ref_tag[idx]   = tag;
        ref_line[idx]  = merge_bytes(ref_line[idx], line, ben);
        ref_valid[idx] = 1'b1;
        ref_dirty[idx] = dirty;
endfunction

// Random tag and offset bits around the line index
function automatic logic [31:0] make_addr(input int idx);
        logic [31:0] addr;
        addr = $urandom;
        addr[OFF_W +: IDX_W] = IDX_W'(idx);
        return addr;
endfunction

// One lookup cycle with an optional write and an optional checked read
task automatic drive_cycle(input logic wr, input int widx, input logic [CACHE_LINE-1:0] ben,
                           input logic rd, input int ridx, input string name,
                           input logic known);
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line;
        logic              dirty;
        tag   = TAG_W'({$urandom, $urandom});
        line  = {$urandom, $urandom};
        dirty = 1'($urandom);
        @(posedge i_clk);
        i_cache_tag_wr_en <= wr;
        i_address         <= make_addr(widx);
        i_cache_tag       <= tag;
        i_cache_line      <= line;
        i_cache_line_ben  <= ben;
        i_cache_tag_dirty <= dirty;
        i_address_nxt     <= make_addr(ridx);
        if (wr)
                model_write(widx, tag, line, ben, dirty);
        rd_req       <= rd;
        rd_name      <= name;
        rd_known     <= known;
        rd_exp_tag   <= ref_tag[ridx];
        rd_exp_line  <= ref_line[ridx];
        rd_exp_valid <= ref_valid[ridx];
        rd_exp_dirty <= ref_dirty[ridx];
endtask

task automatic read_all(input string name);
        for (int idx = 0; idx < LINES; idx++)
                drive_cycle(1'b0, 0, '0, 1'b1, idx, name, 1'b1);
        drive_cycle(1'b0, 0, '0, 1'b0, 0, "idle", 1'b0);
endtask

task automatic run_clean();
        int cycles;
        for (int idx = 0; idx < LINES; idx++)
                if (ref_dirty[idx])
                        for (int k = 0; k < WORDS; k++)
                                exp_bus.push_back(bus_word(idx, k));
        @(posedge i_clk);
        i_cache_clean_req <= 1'b1;
        cycles = 0;
        do
        begin
                @(negedge i_clk);
                cycles++;
                assert (cycles <= CLEAN_TIMEOUT)
                else
                begin
                        $display("clean done did not arrive within %0d cycles", CLEAN_TIMEOUT);
                        abort_run();
                end
        end
        while (!o_cache_clean_done);
        @(posedge i_clk);
        i_cache_clean_req <= 1'b0;
        assert (exp_bus.size() == 0)
        else
        begin
                $display("clean finished with %0d bus words not written", exp_bus.size());
                abort_run();
        end
        for (int idx = 0; idx < LINES; idx++)
                ref_dirty[idx] = 1'b0;
endtask

// Done follows the request by one cycle and lasts one cycle
task automatic run_invalidate();
        @(posedge i_clk);
        i_cache_inv_req <= 1'b1;
        @(negedge i_clk);
        check_value("inv_done early", 64'(1'b0), 64'(o_cache_inv_done));
        @(posedge i_clk);
        i_cache_inv_req <= 1'b0;
        @(negedge i_clk);
        check_value("inv_done", 64'(1'b1), 64'(o_cache_inv_done));
        @(negedge i_clk);
        check_value("inv_done length", 64'(1'b0), 64'(o_cache_inv_done));
        for (int idx = 0; idx < LINES; idx++)
                ref_valid[idx] = 1'b0;
endtask

// --------------------------------------------------
// Bus responder that acks after 0 to 3 idle cycles
// --------------------------------------------------

always @(posedge i_clk)
begin
        if (i_reset)
                i_wb_ack <= 1'b0;
        else if (i_wb_ack)
        begin
                i_wb_ack  <= 1'b0;
                ack_delay <= 2'($urandom_range(0, 3));
        end
        else if (o_wb_stb)
        begin
                if (ack_delay == 2'd0)
                        i_wb_ack <= 1'b1;
                else
                        ack_delay <= ack_delay - 2'd1;
        end
end

// --------------------------------------------------
// Comparing process
// --------------------------------------------------

always @(posedge i_clk)
begin
        cmp_pending <= rd_req;
        cmp_name    <= rd_name;
        cmp_known   <= rd_known;
        cmp_tag     <= rd_exp_tag;
        cmp_line    <= rd_exp_line;
        cmp_valid   <= rd_exp_valid;
        cmp_dirty   <= rd_exp_dirty;
end

always @(negedge i_clk)
begin
        if (cmp_pending)
        begin
                check_value({cmp_name, " valid"}, 64'(cmp_valid), 64'(o_cache_tag_valid));
                check_value({cmp_name, " dirty"}, 64'(cmp_dirty), 64'(o_cache_tag_dirty));
                if (cmp_known)
                begin
                        check_value({cmp_name, " tag"}, 64'(cmp_tag), 64'(o_cache_tag));
                        check_value({cmp_name, " line"}, cmp_line, o_cache_line);
                end
        end

        // Each word is compared on the cycle its ack is taken
        if (o_wb_stb && i_wb_ack)
        begin
                assert (exp_bus.size() != 0)
                else
                begin
                        $display("bus word at %h acked with no write-back expected", o_wb_adr);
                        abort_run();
                end
                if (exp_bus.size() != 0)
                begin
                        bus_exp = exp_bus.pop_front();
                        check_value("clean adr", 64'(bus_exp[66:35]), 64'(o_wb_adr));
                        check_value("clean dat", 64'(bus_exp[34:3]), 64'(o_wb_dat));
                        check_value("clean cti", 64'(bus_exp[2:0]), 64'(o_wb_cti));
                        check_value("clean cyc", 64'(1'b1), 64'(o_wb_cyc));
                        check_value("clean we", 64'(1'b1), 64'(o_wb_we));
                        check_value("clean sel", 64'(4'hf), 64'(o_wb_sel));
                end
        end
end

// --------------------------------------------------
// Stimulus
// --------------------------------------------------

initial
begin
        int cycles;
        int idx;
        void'($urandom(32'h1f63ec3a));
        for (int i = 0; i < LINES; i++)
        begin
                ref_valid[i] = 1'b0;
                ref_dirty[i] = 1'b0;
        end

        cycles = 0;
        while (i_reset)
        begin
                @(posedge i_clk);
                cycles++;
                assert (cycles < 50)
                else
                begin
                        $display("reset was never released");
                        abort_run();
                end
        end

        // Reset state
        @(negedge i_clk);
        check_value("reset cyc", 64'(1'b0), 64'(o_wb_cyc));
        check_value("reset stb", 64'(1'b0), 64'(o_wb_stb));
        check_value("reset we", 64'(1'b0), 64'(o_wb_we));
        check_value("reset sel", 64'(4'h0), 64'(o_wb_sel));
        check_value("reset cti", 64'(3'b000), 64'(o_wb_cti));
        check_value("reset clean_done", 64'(1'b0), 64'(o_cache_clean_done));
        check_value("reset inv_done", 64'(1'b0), 64'(o_cache_inv_done));
        for (int i = 0; i < 16; i++)
                drive_cycle(1'b0, 0, '0, 1'b1, int'($urandom_range(0, LINES - 1)), "reset", 1'b0);

        // Fill every line so all later reads have known data
        for (int i = 0; i < LINES; i++)
                drive_cycle(1'b1, i, '1, 1'b0, 0, "fill", 1'b0);

        // Write then read back with random byte enables
        for (int i = 0; i < 200; i++)
        begin
                idx = int'($urandom_range(0, LINES - 1));
                drive_cycle(1'b1, idx, CACHE_LINE'($urandom), 1'b0, 0, "write", 1'b0);
                drive_cycle(1'b0, 0, '0, 1'b1, idx, "write_read", 1'b1);
        end

        // Read and write of one index in the same cycle
        for (int i = 0; i < 32; i++)
        begin
                idx = int'($urandom_range(0, LINES - 1));
                drive_cycle(1'b1, idx, CACHE_LINE'($urandom), 1'b1, idx, "bypass", 1'b1);
        end
        drive_cycle(1'b0, 0, '0, 1'b0, 0, "idle", 1'b0);

        run_clean();
        read_all("after_clean");

        // Dirty some lines again so invalidate has dirty bits to keep
        for (int i = 0; i < 32; i++)
        begin
                idx = int'($urandom_range(0, LINES - 1));
                drive_cycle(1'b1, idx, CACHE_LINE'($urandom), 1'b0, 0, "redirty", 1'b0);
        end
        drive_cycle(1'b0, 0, '0, 1'b0, 0, "idle", 1'b0);

        run_invalidate();
        read_all("after_invalidate");

        @(negedge i_clk);
        @(negedge i_clk);
        $display("Result: PASSED");
        $finish;
end

endmodule

// File: sim.f
common/cache_pkg.sv
common/store_if.sv
design/cache_ram.sv
line_store/line_store.sv
maint_engine/dirty_scan.sv
maint_engine/maint_engine.sv
design/cache_tag_unit.sv
verif/tb_clock.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status is the simulation result.
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_top -o tb_top_sim &&
./obj_dir/tb_top_sim || exit 1
